// File: verilog/tpu_ctrl_pkg.sv
package tpu_ctrl_pkg;

    // matrix unit operations
    typedef enum logic [1:0] {
        OP_NOP        = 2'd0,
        OP_MATMUL     = 2'd1,
        OP_MATMUL_ACC = 2'd2
    } opcode_e;

    // decoded instruction as delivered by the instruction queue
    typedef struct packed {
        opcode_e     opcode;
        // first activation row in the unified buffer
        logic [11:0] ub_addr;
        // first accumulator row
        logic [9:0]  acc_addr;
        // activation vector count, zero is treated as a nop
        logic [7:0]  rows;
    } decoded_instr_t;

    // command travelling down the instruction pipeline
    typedef struct packed {
        logic           valid;
        decoded_instr_t instr;
    } tile_cmd_t;

    // one compute beat handed to the accumulator stage
    typedef struct packed {
        logic       valid;
        // final beat of the tile
        logic       last;
        // accumulate into the row instead of overwriting it
        logic       add;
        logic [9:0] acc_addr;
    } mac_beat_t;

endpackage

// File: verilog/weight_control_unit.sv
`timescale 1ns/1ps

module weight_control_unit import tpu_ctrl_pkg::*; #(
    parameter int MUL_SIZE    = 4,
    parameter int INSTR_DEPTH = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    input  decoded_instr_t      instr_i,
    input  logic                weight_fifo_valid_i,
    input  logic                next_weight_tile_i,
    output logic                instr_credit_o,
    output logic [MUL_SIZE-1:0] load_weights_o,
    output logic                compute_weights_rdy_o,
    output tile_cmd_t           tile_cmd_o
);

    localparam int PTR_W = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(INSTR_DEPTH + 1);
    localparam int ROW_W = (MUL_SIZE > 1) ? $clog2(MUL_SIZE) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READY
    } state_e;

    decoded_instr_t slot_mem [INSTR_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] slot_cnt;
    decoded_instr_t head, cur_instr;
    state_e state;
    logic [ROW_W-1:0] row;
    logic pop, head_runs, last_row;

    assign head = slot_mem[rd_ptr];
    assign head_runs = (head.opcode != OP_NOP) && (head.rows != 8'd0);
    // a slot is freed when idle, or when the running tile hands over
    assign pop = (slot_cnt != '0) &&
                 ((state == ST_IDLE) || ((state == ST_READY) && next_weight_tile_i));
    assign last_row = (row == ROW_W'(MUL_SIZE - 1));

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            slot_mem[wr_ptr] <= instr_i;
        end
        if (pop) begin
            cur_instr <= head;
        end
        tile_cmd_o.instr <= cur_instr;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            slot_cnt <= '0;
            instr_credit_o <= 1'b0;
        end else begin
            if (instr_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            slot_cnt <= slot_cnt + CNT_W'(instr_valid_i) - CNT_W'(pop);
            // every popped slot goes back to the queue as a credit
            instr_credit_o <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
            row <= '0;
            tile_cmd_o.valid <= 1'b0;
        end else begin
            tile_cmd_o.valid <= (state == ST_LOAD) && weight_fifo_valid_i && last_row;
            case (state)
                ST_IDLE: begin
                    if (pop && head_runs) begin
                        state <= ST_LOAD;
                        row <= '0;
                    end
                end
                ST_LOAD: begin
                    if (weight_fifo_valid_i) begin
                        if (last_row) begin
                            state <= ST_READY;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                default: begin
                    if (next_weight_tile_i) begin
                        state <= (pop && head_runs) ? ST_LOAD : ST_IDLE;
                        row <= '0;
                    end
                end
            endcase
        end
    end

    // row strobe only fires when the weight fifo has data
    always_comb begin
        load_weights_o = '0;
        if ((state == ST_LOAD) && weight_fifo_valid_i) begin
            load_weights_o[row] = 1'b1;
        end
    end

    assign compute_weights_rdy_o = (state == ST_READY);

endmodule

// File: verilog/unified_buffer_control_unit.sv
`timescale 1ns/1ps

module unified_buffer_control_unit import tpu_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  tile_cmd_t   tile_cmd_i,
    output logic        unified_buffer_read_en_o,
    output logic [11:0] unified_buffer_addr_rd_o,
    output tile_cmd_t   tile_cmd_o
);

    logic        active;
    logic [7:0]  rows_left;
    logic [11:0] rd_addr;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active <= 1'b0;
            rows_left <= '0;
            rd_addr <= '0;
            tile_cmd_o.valid <= 1'b0;
        end else begin
            tile_cmd_o.valid <= tile_cmd_i.valid;
            if (tile_cmd_i.valid) begin
                // start register, reads begin on the next cycle
                active <= 1'b1;
                rows_left <= tile_cmd_i.instr.rows;
                rd_addr <= tile_cmd_i.instr.ub_addr;
            end else if (active) begin
                rd_addr <= rd_addr + 12'd1;
                rows_left <= rows_left - 8'd1;
                if (rows_left == 8'd1) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // forwarded so that compute lines up with the first read
    always_ff @(posedge clk_i) begin
        tile_cmd_o.instr <= tile_cmd_i.instr;
    end

    assign unified_buffer_read_en_o = active;
    assign unified_buffer_addr_rd_o = rd_addr;

endmodule

// File: verilog/compute_control_unit.sv
`timescale 1ns/1ps

module compute_control_unit import tpu_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  tile_cmd_t tile_cmd_i,
    output logic      MAC_compute_o,
    output logic      next_weight_tile_o,
    output mac_beat_t beat_o
);

    logic       active;
    logic [7:0] beats_left;
    logic [9:0] acc_addr;
    logic       add_mode;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active <= 1'b0;
            beats_left <= '0;
        end else begin
            if (tile_cmd_i.valid) begin
                active <= 1'b1;
                beats_left <= tile_cmd_i.instr.rows;
            end else if (active) begin
                beats_left <= beats_left - 8'd1;
                if (beats_left == 8'd1) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // address walks with the beat, wraps at the top of the accumulator
    always_ff @(posedge clk_i) begin
        if (tile_cmd_i.valid) begin
            acc_addr <= tile_cmd_i.instr.acc_addr;
            add_mode <= (tile_cmd_i.instr.opcode == OP_MATMUL_ACC);
        end else if (active) begin
            acc_addr <= acc_addr + 10'd1;
        end
    end

    always_comb begin
        beat_o.valid = active;
        beat_o.last = active && (beats_left == 8'd1);
        beat_o.add = add_mode;
        beat_o.acc_addr = acc_addr;
    end

    assign MAC_compute_o = active;
    // weights may be swapped once the final activation has entered the array
    assign next_weight_tile_o = beat_o.last;

endmodule

// File: verilog/accumulator_control_unit.sv
`timescale 1ns/1ps

module accumulator_control_unit import tpu_ctrl_pkg::*; #(
    parameter int MUL_SIZE = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  mac_beat_t  beat_i,
    output logic       write_accumulator_o,
    output logic [9:0] accumulator_addr_wr_o,
    output logic       accumulator_add_o,
    output logic       done_o
);

    // one stage per array row, results leave the array MUL_SIZE cycles late
    mac_beat_t skew [MUL_SIZE];
    mac_beat_t wr_beat;

    assign wr_beat = skew[MUL_SIZE-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MUL_SIZE; i++) begin
                skew[i].valid <= 1'b0;
            end
        end else begin
            skew[0].valid <= beat_i.valid;
            for (int i = 1; i < MUL_SIZE; i++) begin
                skew[i].valid <= skew[i-1].valid;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        skew[0].last <= beat_i.last;
        skew[0].add <= beat_i.add;
        skew[0].acc_addr <= beat_i.acc_addr;
        for (int i = 1; i < MUL_SIZE; i++) begin
            skew[i].last <= skew[i-1].last;
            skew[i].add <= skew[i-1].add;
            skew[i].acc_addr <= skew[i-1].acc_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            // tile complete once its final row has been written
            done_o <= wr_beat.valid && wr_beat.last;
        end
    end

    assign write_accumulator_o = wr_beat.valid;
    assign accumulator_addr_wr_o = wr_beat.acc_addr;
    assign accumulator_add_o = wr_beat.valid && wr_beat.add;

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit import tpu_ctrl_pkg::*; #(
    parameter int MUL_SIZE    = 4,
    parameter int INSTR_DEPTH = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    input  decoded_instr_t      instr_i,
    input  logic                weight_fifo_valid_i,
    output logic                instr_credit_o,
    output logic [MUL_SIZE-1:0] load_weights_o,
    output logic                compute_weights_rdy_o,
    output logic                unified_buffer_read_en_o,
    output logic [11:0]         unified_buffer_addr_rd_o,
    output logic                MAC_compute_o,
    output logic                write_accumulator_o,
    output logic [9:0]          accumulator_addr_wr_o,
    output logic                accumulator_add_o,
    output logic                done_o
);

    tile_cmd_t weight_cmd, weight_cmd_q, buf_cmd;
    mac_beat_t mac_beat;
    logic      next_weight_tile;

    weight_control_unit #(
        .MUL_SIZE    (MUL_SIZE),
        .INSTR_DEPTH (INSTR_DEPTH)
    ) u_weight_ctrl (
        .clk_i,
        .rst_n_i,
        .instr_valid_i,
        .instr_i,
        .weight_fifo_valid_i,
        .next_weight_tile_i (next_weight_tile),
        .instr_credit_o,
        .load_weights_o,
        .compute_weights_rdy_o,
        .tile_cmd_o         (weight_cmd)
    );

    // pipeline register between weight and buffer stages
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            weight_cmd_q.valid <= 1'b0;
        end else begin
            weight_cmd_q.valid <= weight_cmd.valid;
        end
        weight_cmd_q.instr <= weight_cmd.instr;
    end

    unified_buffer_control_unit u_buf_ctrl (
        .clk_i,
        .rst_n_i,
        .tile_cmd_i (weight_cmd_q),
        .unified_buffer_read_en_o,
        .unified_buffer_addr_rd_o,
        .tile_cmd_o (buf_cmd)
    );

    compute_control_unit u_comp_ctrl (
        .clk_i,
        .rst_n_i,
        .tile_cmd_i         (buf_cmd),
        .MAC_compute_o,
        .next_weight_tile_o (next_weight_tile),
        .beat_o             (mac_beat)
    );

    accumulator_control_unit #(
        .MUL_SIZE (MUL_SIZE)
    ) u_accum_ctrl (
        .clk_i,
        .rst_n_i,
        .beat_i (mac_beat),
        .write_accumulator_o,
        .accumulator_addr_wr_o,
        .accumulator_add_o,
        .done_o
    );

endmodule

// File: dv/control_unit_assert.sv
`timescale 1ns/1ps

module control_unit_assert #(
    parameter int MUL_SIZE    = 4,
    parameter int INSTR_DEPTH = 2
) (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                instr_valid_i,
    input logic                instr_credit_i,
    input logic [MUL_SIZE-1:0] load_weights_i
);

    // credits held by the instruction queue
    int credits;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits <= INSTR_DEPTH;
        end else begin
            credits <= credits + int'(instr_credit_i) - int'(instr_valid_i);
        end
    end

    valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i |-> (credits != 0))
        else $error("instruction beat sent with no credit left");

    credits_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (credits >= 0) && (credits < INSTR_DEPTH + 1))
        else $error("queue credit count out of range");

    row_load_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(load_weights_i))
        else $error("more than one weight row loaded in a cycle");

endmodule

bind control_unit control_unit_assert #(
    .MUL_SIZE    (MUL_SIZE),
    .INSTR_DEPTH (INSTR_DEPTH)
) u_assert (
    .clk_i,
    .rst_n_i,
    .instr_valid_i,
    .instr_credit_i (instr_credit_o),
    .load_weights_i (load_weights_o)
);

// File: dv/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb import tpu_ctrl_pkg::*; ();

    localparam int MUL_SIZE    = 4;
    localparam int INSTR_DEPTH = 2;
    localparam int TIMEOUT     = 2000;
    localparam logic [31:0] SEED = 32'h1cbc;

    logic                clk_i = 1'b0;
    logic                rst_n_i = 1'b0;
    logic                instr_valid_i = 1'b0;
    decoded_instr_t      instr_i = '0;
    logic                weight_fifo_valid_i = 1'b1;
    logic                instr_credit_o, compute_weights_rdy_o;
    logic [MUL_SIZE-1:0] load_weights_o;
    logic                unified_buffer_read_en_o, MAC_compute_o;
    logic [11:0]         unified_buffer_addr_rd_o;
    logic                write_accumulator_o, accumulator_add_o, done_o;
    logic [9:0]          accumulator_addr_wr_o;

    // queue side credit model and event counters
    int cyc = 0;
    int credits = INSTR_DEPTH;
    int credit_cnt = 0;
    int done_cnt = 0;
    int exp_credits = 0;
    int exp_done = 0;
    logic rdy_prev = 1'b0;
    logic last_row_prev = 1'b0;
    logic loading = 1'b0;
    logic stall_en = 1'b0;
    logic [31:0] rng = SEED;
    logic [31:0] stall_rng = ~SEED;

    decoded_instr_t sent_q[$];
    int rdy_cyc_q[$], load_q[$], rd_addr_q[$], rd_cyc_q[$], mac_cyc_q[$];
    int wr_addr_q[$], wr_add_q[$], wr_cyc_q[$], done_cyc_q[$];

    control_unit #(
        .MUL_SIZE    (MUL_SIZE),
        .INSTR_DEPTH (INSTR_DEPTH)
    ) uut (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int next_rand();
        rng = xorshift(rng);
        return int'(rng[30:0]);
    endfunction

    function automatic decoded_instr_t random_instr(input opcode_e op);
        decoded_instr_t ins;
        ins.opcode = op;
        ins.ub_addr = 12'(next_rand());
        ins.acc_addr = 10'(next_rand());
        ins.rows = 8'(next_rand() % 8 + 1);
        return ins;
    endfunction

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            stop_run();
        end
    endtask

    // samples every output at the rising edge, before the DUT updates
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        stall_rng <= xorshift(stall_rng);
        weight_fifo_valid_i <= !stall_en || (stall_rng[1:0] != 2'b00);
        rdy_prev <= compute_weights_rdy_o;
        last_row_prev <= load_weights_o[MUL_SIZE-1];
        if (!rst_n_i) begin
            credits <= INSTR_DEPTH;
        end else begin
            credits <= credits + int'(instr_credit_o) - int'(instr_valid_i);
            if (instr_credit_o) begin
                credit_cnt <= credit_cnt + 1;
            end
            if (load_weights_o != '0) begin
                check(int'(weight_fifo_valid_i), 1, "weight fifo valid during row load");
                load_q.push_back(int'(load_weights_o));
                // between the first and the last row only an empty fifo holds the load
                loading <= !load_weights_o[MUL_SIZE-1];
            end else if (loading) begin
                check(int'(weight_fifo_valid_i), 0, "weight fifo valid without a row load");
            end
            if (compute_weights_rdy_o && !rdy_prev) begin
                check(int'(last_row_prev), 1, "weights ready right after the last row");
                rdy_cyc_q.push_back(cyc);
            end
            if (unified_buffer_read_en_o) begin
                rd_addr_q.push_back(int'(unified_buffer_addr_rd_o));
                rd_cyc_q.push_back(cyc);
            end
            if (MAC_compute_o) begin
                mac_cyc_q.push_back(cyc);
            end
            if (write_accumulator_o) begin
                wr_addr_q.push_back(int'(accumulator_addr_wr_o));
                wr_add_q.push_back(int'(accumulator_add_o));
                wr_cyc_q.push_back(cyc);
            end
            if (done_o) begin
                done_cnt <= done_cnt + 1;
                done_cyc_q.push_back(cyc);
            end
        end
    end

    task automatic send_instr(input decoded_instr_t ins);
        int n;
        n = 0;
        @(posedge clk_i);
        // credits left once this edge has been accounted for
        while (credits + int'(instr_credit_o) - int'(instr_valid_i) <= 0) begin
            instr_valid_i <= 1'b0;
            if (n == TIMEOUT) begin
                $display("timeout: no instruction credit came back in %0d cycles", TIMEOUT);
                stop_run();
            end
            n++;
            @(posedge clk_i);
        end
        instr_valid_i <= 1'b1;
        instr_i <= ins;
        sent_q.push_back(ins);
        exp_credits++;
        if (ins.opcode != OP_NOP && ins.rows != 8'd0) begin
            exp_done++;
        end
    endtask

    task automatic release_queue();
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (done_cnt != exp_done || credit_cnt != exp_credits) begin
            if (n == TIMEOUT) begin
                $display("timeout: %s did not finish within %0d cycles", what, TIMEOUT);
                stop_run();
            end
            n++;
            @(posedge clk_i);
        end
        check(credits, INSTR_DEPTH, "queue credits after drain");
    endtask

    // expected event stream per tile, taken relative to the ready rise
    task automatic check_tiles();
        decoded_instr_t ins;
        int c, tiles, total;
        tiles = 0;
        total = 0;
        foreach (sent_q[i]) begin
            if (sent_q[i].opcode != OP_NOP && sent_q[i].rows != 8'd0) begin
                tiles++;
                total += int'(sent_q[i].rows);
            end
        end
        check(rdy_cyc_q.size(), tiles, "weights ready count");
        check(load_q.size(), tiles * MUL_SIZE, "weight row load count");
        check(rd_addr_q.size(), total, "buffer read count");
        check(mac_cyc_q.size(), total, "compute beat count");
        check(wr_addr_q.size(), total, "accumulator write count");
        check(done_cyc_q.size(), tiles, "done count");
        while (sent_q.size() > 0) begin
            ins = sent_q.pop_front();
            if (ins.opcode != OP_NOP && ins.rows != 8'd0) begin
                c = rdy_cyc_q.pop_front();
                for (int r = 0; r < MUL_SIZE; r++) begin
                    check(load_q.pop_front(), 1 << r, "weight row strobe");
                end
                for (int k = 0; k < int'(ins.rows); k++) begin
                    check(rd_addr_q.pop_front(), (int'(ins.ub_addr) + k) % 4096, "read address");
                    check(rd_cyc_q.pop_front(), c + 2 + k, "read cycle");
                    check(mac_cyc_q.pop_front(), c + 3 + k, "compute cycle");
                    check(wr_addr_q.pop_front(), (int'(ins.acc_addr) + k) % 1024,
                          "write address");
                    check(wr_add_q.pop_front(), int'(ins.opcode == OP_MATMUL_ACC),
                          "accumulate flag");
                    check(wr_cyc_q.pop_front(), c + 3 + MUL_SIZE + k, "write cycle");
                end
                check(done_cyc_q.pop_front(), c + 3 + MUL_SIZE + int'(ins.rows), "done cycle");
            end
        end
    endtask

    task automatic check_outputs_low(input string what);
        check(int'({instr_credit_o, |load_weights_o, compute_weights_rdy_o,
                    unified_buffer_read_en_o, MAC_compute_o, write_accumulator_o,
                    accumulator_add_o, done_o}), 0, what);
    endtask

    task automatic reset_test();
        // edge 0 still shows pre-reset values
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            if (i > 0) begin
                check_outputs_low("control outputs during reset");
            end
        end
        rst_n_i <= 1'b1;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk_i);
            check_outputs_low("control outputs after reset");
        end
    endtask

    task automatic run_tiles(input decoded_instr_t list[$], input string what);
        foreach (list[i]) begin
            send_instr(list[i]);
        end
        release_queue();
        wait_idle(what);
        check_tiles();
    endtask

    task automatic single_matmul_test();
        decoded_instr_t list[$];
        list.push_back(random_instr(OP_MATMUL));
        run_tiles(list, "single matmul");
    endtask

    task automatic accumulate_wrap_test();
        decoded_instr_t list[$];
        decoded_instr_t ins;
        ins = random_instr(OP_MATMUL_ACC);
        ins.acc_addr = 10'd1021;
        ins.rows = 8'd6;
        list.push_back(ins);
        run_tiles(list, "accumulate with wrap");
    endtask

    task automatic backpressure_test();
        decoded_instr_t list[$];
        stall_en <= 1'b1;
        list.push_back(random_instr(OP_MATMUL));
        run_tiles(list, "weight fifo stall");
    endtask

    task automatic burst_test();
        decoded_instr_t list[$];
        for (int i = 0; i < 8; i++) begin
            list.push_back(random_instr(opcode_e'(2'(next_rand() % 3))));
        end
        run_tiles(list, "instruction burst");
    endtask

    initial begin
        reset_test();
        single_matmul_test();
        accumulate_wrap_test();
        backpressure_test();
        burst_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
verilog/tpu_ctrl_pkg.sv
verilog/weight_control_unit.sv
verilog/unified_buffer_control_unit.sv
verilog/compute_control_unit.sv
verilog/accumulator_control_unit.sv
verilog/control_unit.sv
dv/control_unit_assert.sv
dv/control_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the control unit testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module control_unit_tb -f files.f -o sim_control_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_control_unit 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
